// File: hdl/uartBaudGen.sv
//////////////////////////////
// 16x oversampling tick, one pulse every divisor+1 clocks
// Divisor of zero ticks on every clock
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartBaudGen #(
   parameter int divWidth = 16
) (
   input  wire                clk,
   input  wire                rst,
   input  wire [divWidth-1:0] divisor,
   output logic               tick
);

   logic [divWidth-1:0] count;
   // Last divisor seen, to spot a rate change
   logic [divWidth-1:0] divPrev;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count   <= '0;
         divPrev <= '0;
         tick    <= 1'b0;
      end
      else
      begin
         divPrev <= divisor;
         tick    <= 1'b0;
         // New rate restarts the count
         if (divisor != divPrev)
            count <= divisor;
         else if (count == '0)
         begin
            count <= divisor;
            tick  <= 1'b1;
         end
         else
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hdl/uartPkg.sv
//////////////////////////////
// Shared UART types and the register map
// CTRL bits 4:0 carry lineCfg as laid out here
// Reserved parity code behaves as no parity
//////////////////////////////

`default_nettype none

package uartPkg;

   // Character length, 5 to 8 data bits
   typedef enum logic [1:0] {
      len5,
      len6,
      len7,
      len8
   } charLength;

   // Parity selection
   typedef enum logic [1:0] {
      parNone,
      parEven,
      parOdd,
      parRsvd
   } parityMode;

   typedef enum logic {
      stop1,
      stop2
   } stopBits;

   // Line format, length in 4:3, parity in 2:1, stop in 0
   typedef struct packed {
      charLength length;
      parityMode parity;
      stopBits   stop;
   } lineCfg;

   // Receiver flags, full in bit 3 down to ovre in bit 0
   typedef struct packed {
      logic full;
      logic pare;
      logic frme;
      logic ovre;
   } rxStatus;

   // Word offsets, decoded from bus address bits 3:2
   typedef enum logic [1:0] {
      regCtrl   = 2'd0,
      regDiv    = 2'd1,
      regStatus = 2'd2,
      regData   = 2'd3
   } regAddr;

   // Bit positions outside the packed fields
   localparam int ctrlRxIntEnBit = 5;
   localparam int ctrlTxIntEnBit = 6;
   localparam int statTxReadyBit = 4;

endpackage

`default_nettype wire

// File: hdl/uartRegs.sv
//////////////////////////////
// Wishbone classic register block
// Ack one cycle after the request, no wait states
// Master drops wbStb after ack
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRegs #(
   parameter int                divWidth = 16,
   parameter logic [divWidth-1:0] resetDiv = '0
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   wbCyc,
   input  wire                   wbStb,
   input  wire                   wbWe,
   input  wire [3:0]             wbAdr,
   input  wire [31:0]            wbDatW,
   output logic [31:0]           wbDatR,
   output logic                  wbAck,
   input  wire [7:0]             rxData,
   input  wire uartPkg::rxStatus rxStat,
   input  wire                   txReady,
   output uartPkg::lineCfg       cfg,
   output logic [divWidth-1:0]   divisor,
   output logic                  rxClear,
   output logic                  rxTaken,
   output logic                  txLoad,
   output logic [7:0]            txData,
   output logic                  irq
);

   import uartPkg::*;

   regAddr      addr;
   logic        access;
   logic        rxIntEn;
   logic        txIntEn;
   logic [31:0] readMux;

   //////////////////////////////
   // Bus decode
   //////////////////////////////

   assign addr   = regAddr'(wbAdr[3:2]);
   // New request, not already acked
   assign access = wbCyc && wbStb && !wbAck;

   // Read data
   always_comb
   begin
      readMux = 32'd0;
      case (addr)
         regCtrl:
         begin
            readMux[4:0]           = cfg;
            readMux[ctrlRxIntEnBit] = rxIntEn;
            readMux[ctrlTxIntEnBit] = txIntEn;
         end
         regDiv:
            readMux[divWidth-1:0] = divisor;
         regStatus:
         begin
            readMux[3:0]           = rxStat;
            readMux[statTxReadyBit] = txReady;
         end
         default:
            readMux[7:0] = rxData;
      endcase
   end

   //////////////////////////////
   // Registers and strobes
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wbAck   <= 1'b0;
         cfg     <= '0;
         rxIntEn <= 1'b0;
         txIntEn <= 1'b0;
         divisor <= resetDiv;
         rxClear <= 1'b0;
         rxTaken <= 1'b0;
         txLoad  <= 1'b0;
      end
      else
      begin
         wbAck   <= access;
         // Strobes last one cycle
         rxClear <= 1'b0;
         rxTaken <= 1'b0;
         txLoad  <= 1'b0;
         if (access && wbWe)
            case (addr)
               regCtrl:
               begin
                  cfg     <= lineCfg'(wbDatW[4:0]);
                  rxIntEn <= wbDatW[ctrlRxIntEnBit];
                  txIntEn <= wbDatW[ctrlTxIntEnBit];
                  rxClear <= 1'b1;
               end
               regDiv:
                  divisor <= wbDatW[divWidth-1:0];
               regData:
                  // Dropped while a character is still going out
                  txLoad <= txReady;
               default:
                  ;
            endcase
         else if (access && (addr == regData))
            rxTaken <= 1'b1;
      end
   end

   // Read data and TX character, valid with ack
   always_ff @(posedge clk)
   begin
      if (access)
         wbDatR <= readMux;
      if (access && wbWe && (addr == regData))
         txData <= wbDatW[7:0];
   end

   // Interrupt, level sensitive
   assign irq = (rxStat.full && rxIntEn) || (txReady && txIntEn);

endmodule

`default_nettype wire

// File: hdl/uartRx.sv
//////////////////////////////
// Unbuffered receiver, 16 ticks per bit, LSB first
// Format is read live, so change it only while idle
// Short characters come out with zero upper bits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRx (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  clear,
   input  wire                  tick,
   input  wire uartPkg::lineCfg cfg,
   input  wire                  rxd,
   input  wire                  taken,
   output logic [7:0]           data,
   output uartPkg::rxStatus     status
);

   import uartPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stStart,
      stData,
      stParity,
      stStop1,
      stStop2,
      stWait,
      stDone
   } rxState;

   rxState     state;
   logic       rxMeta;
   logic       rxSync;
   logic [3:0] tickCnt;
   logic [2:0] bitCnt;
   logic [2:0] lastBit;
   logic [7:0] shiftReg;
   logic       parErr;
   logic       frmErr;
   logic       parityOn;
   logic       expParity;
   logic       bitTick;

   //////////////////////////////
   // Line synchronizer
   //////////////////////////////

   // Idle line is high
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rxMeta <= 1'b1;
         rxSync <= 1'b1;
      end
      else
      begin
         rxMeta <= rxd;
         rxSync <= rxMeta;
      end
   end

   //////////////////////////////
   // Format decode
   //////////////////////////////

   // Index of the last data bit, 4 to 7
   assign lastBit  = {1'b1, cfg.length};
   assign parityOn = (cfg.parity == parEven) || (cfg.parity == parOdd);
   // Upper bits of shiftReg are zero, so they drop out of the XOR
   assign expParity = (^shiftReg) ^ (cfg.parity == parOdd);
   // Sample point, end of the tick count
   assign bitTick  = tick && (tickCnt == 4'd0);

   //////////////////////////////
   // Receive FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         state   <= stIdle;
         tickCnt <= 4'd0;
         bitCnt  <= 3'd0;
         parErr  <= 1'b0;
         frmErr  <= 1'b0;
         status  <= '0;
      end
      else
      begin
         // Common tick countdown
         if (tick && (tickCnt != 4'd0))
            tickCnt <= tickCnt - 1'b1;
         if (taken)
            status.full <= 1'b0;

         case (state)
            stIdle:
               // Falling edge seen on a tick
               if (tick && !rxSync)
               begin
                  tickCnt <= 4'd7;
                  state   <= stStart;
               end
            stStart:
               // Start bit must stay low to mid-bit, else a glitch
               if (tick && rxSync)
                  state <= stIdle;
               else if (bitTick)
               begin
                  tickCnt     <= 4'd15;
                  bitCnt      <= 3'd0;
                  shiftReg    <= 8'd0;
                  parErr      <= 1'b0;
                  frmErr      <= 1'b0;
                  status.pare <= 1'b0;
                  status.frme <= 1'b0;
                  status.ovre <= 1'b0;
                  state       <= stData;
               end
            stData:
               if (bitTick)
               begin
                  tickCnt          <= 4'd15;
                  shiftReg[bitCnt] <= rxSync;
                  bitCnt           <= bitCnt + 1'b1;
                  if (bitCnt == lastBit)
                     state <= parityOn ? stParity : stStop1;
               end
            stParity:
               if (bitTick)
               begin
                  parErr  <= (rxSync != expParity);
                  tickCnt <= 4'd15;
                  state   <= stStop1;
               end
            stStop1:
               if (bitTick)
               begin
                  frmErr <= !rxSync;
                  if (cfg.stop == stop2)
                  begin
                     tickCnt <= 4'd15;
                     state   <= stStop2;
                  end
                  else
                  begin
                     // Half a bit to the end of the stop bit
                     tickCnt <= 4'd7;
                     state   <= stWait;
                  end
               end
            stStop2:
               if (bitTick)
               begin
                  frmErr  <= frmErr || !rxSync;
                  tickCnt <= 4'd7;
                  state   <= stWait;
               end
            stWait:
               if (bitTick)
                  state <= stDone;
            stDone:
            begin
               // Publish the character, overrun if unread
               status.full <= 1'b1;
               status.ovre <= status.full;
               status.pare <= parErr;
               status.frme <= frmErr;
               state       <= stIdle;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   // Output character, held until the next one completes
   always_ff @(posedge clk)
   begin
      if (state == stDone)
         data <= shiftReg;
   end

endmodule

`default_nettype wire

// File: hdl/uartTop.sv
//////////////////////////////
// UART with a Wishbone classic slave
// Registers are 32-bit words at byte offsets 0 to 12
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTop #(
   parameter int                  divWidth = 16,
   parameter logic [divWidth-1:0] resetDiv = 27
) (
   input  wire         clk,
   input  wire         rst,
   input  wire         wbCyc,
   input  wire         wbStb,
   input  wire         wbWe,
   input  wire  [3:0]  wbAdr,
   input  wire  [31:0] wbDatW,
   output logic [31:0] wbDatR,
   output logic        wbAck,
   input  wire         rxd,
   output logic        txd,
   output logic        irq
);

   import uartPkg::*;

   // Register block to datapath
   lineCfg              cfg;
   logic [divWidth-1:0] divisor;
   logic                rxClear;
   logic                rxTaken;
   logic                txLoad;
   logic [7:0]          txData;
   // Datapath back to register block
   logic                tick;
   logic [7:0]          rxData;
   rxStatus             rxStat;
   logic                txReady;

   uartRegs #(
      .divWidth (divWidth),
      .resetDiv (resetDiv)
   ) i_regs (
      .clk     (clk),
      .rst     (rst),
      .wbCyc   (wbCyc),
      .wbStb   (wbStb),
      .wbWe    (wbWe),
      .wbAdr   (wbAdr),
      .wbDatW  (wbDatW),
      .wbDatR  (wbDatR),
      .wbAck   (wbAck),
      .rxData  (rxData),
      .rxStat  (rxStat),
      .txReady (txReady),
      .cfg     (cfg),
      .divisor (divisor),
      .rxClear (rxClear),
      .rxTaken (rxTaken),
      .txLoad  (txLoad),
      .txData  (txData),
      .irq     (irq)
   );

   uartBaudGen #(
      .divWidth (divWidth)
   ) i_baud (
      .clk     (clk),
      .rst     (rst),
      .divisor (divisor),
      .tick    (tick)
   );

   uartRx i_rx (
      .clk    (clk),
      .rst    (rst),
      .clear  (rxClear),
      .tick   (tick),
      .cfg    (cfg),
      .rxd    (rxd),
      .taken  (rxTaken),
      .data   (rxData),
      .status (rxStat)
   );

   uartTx i_tx (
      .clk   (clk),
      .rst   (rst),
      .tick  (tick),
      .cfg   (cfg),
      .load  (txLoad),
      .data  (txData),
      .txd   (txd),
      .ready (txReady)
   );

endmodule

`default_nettype wire

// File: hdl/uartTx.sv
//////////////////////////////
// Unbuffered transmitter, 16 ticks per bit
// Character and format latch on load
// load is ignored while ready is low
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTx (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  tick,
   input  wire uartPkg::lineCfg cfg,
   input  wire                  load,
   input  wire [7:0]            data,
   output logic                 txd,
   output logic                 ready
);

   import uartPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stStart,
      stData,
      stParity,
      stStop1,
      stStop2
   } txState;

   txState     state;
   lineCfg     fmt;
   logic [7:0] shiftReg;
   logic [7:0] charMask;
   logic       parBit;
   logic [3:0] tickCnt;
   logic [2:0] bitCnt;
   logic       bitEnd;

   // Keep only the configured data bits
   assign charMask = 8'hFF >> (3'd3 - {1'b0, cfg.length});
   // Last tick of the current bit
   assign bitEnd   = tick && (tickCnt == 4'd15);
   assign ready    = (state == stIdle);

   //////////////////////////////
   // Transmit FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= stIdle;
         tickCnt <= 4'd0;
         bitCnt  <= 3'd0;
         txd     <= 1'b1;
      end
      else if (state == stIdle)
      begin
         if (load)
         begin
            tickCnt <= 4'd0;
            bitCnt  <= 3'd0;
            // Start bit goes out right away
            txd     <= 1'b0;
            state   <= stStart;
         end
      end
      else
      begin
         if (tick)
            tickCnt <= tickCnt + 1'b1;
         if (bitEnd)
            case (state)
               stStart:
               begin
                  txd   <= shiftReg[0];
                  state <= stData;
               end
               stData:
                  if (bitCnt == {1'b1, fmt.length})
                  begin
                     if ((fmt.parity == parEven) || (fmt.parity == parOdd))
                     begin
                        txd   <= parBit;
                        state <= stParity;
                     end
                     else
                     begin
                        txd   <= 1'b1;
                        state <= stStop1;
                     end
                  end
                  else
                  begin
                     bitCnt <= bitCnt + 1'b1;
                     txd    <= shiftReg[bitCnt + 3'd1];
                  end
               stParity:
               begin
                  txd   <= 1'b1;
                  state <= stStop1;
               end
               stStop1:
                  state <= (fmt.stop == stop2) ? stStop2 : stIdle;
               default:
                  state <= stIdle;
            endcase
      end
   end

   // Character, format and parity captured at load
   always_ff @(posedge clk)
   begin
      if (ready && load)
      begin
         shiftReg <= data & charMask;
         fmt      <= cfg;
         parBit   <= (^(data & charMask)) ^ (cfg.parity == parOdd);
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary -j 0 --top-module uartTopTb -f uartTop.f -o uartTopSim && \
./obj_dir/uartTopSim || exit 1

// File: sim/uartTestdata.txt
# mode ctrl(hex) char(hex) fault(0 none, 1 parity, 2 stop) data(hex) status(hex)
# status bits: 4 txReady, 3 full, 2 pare, 1 frme, 0 ovre
loop 18 a5 0 a5 18
loop 18 3c 0 3c 18
loop 00 55 0 15 18
loop 03 f7 0 17 18
loop 05 ae 0 0e 18
loop 0b 9d 0 1d 18
loop 0d 6a 0 2a 18
loop 13 d3 0 53 18
loop 15 80 0 00 18
loop 1b ff 0 ff 18
loop 1d 01 0 01 18
loop 12 41 0 41 18
loop 1e 96 0 96 18
inject 1b c3 1 c3 1c
inject 1b 5a 0 5a 18
inject 0d 77 2 37 1a
inject 0d 21 0 21 18
inject 12 e9 1 69 1c
inject 12 a6 2 26 1a
inject 12 0f 0 0f 18
inject 05 ff 1 1f 1c
inject 05 00 0 00 18
overrun 18 4b 0 4b 19
overrun 0b 2c 0 2c 19
loop 38 c6 0 c6 18
loop 58 19 0 19 18
loop 78 e4 0 e4 18
inject 38 7e 0 7e 18

// File: sim/uartTopTb.sv
//////////////////////////////
// Testbench for uartTop with tests from sim/uartTestdata.txt
// Run from the project root so the data file is found
// Divisor 3 gives 64 clocks per serial bit
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTopTb;

   localparam logic [15:0] resetDiv  = 16'd100;
   localparam int          testDiv   = 3;
   localparam int          bitClocks = 16 * (testDiv + 1);

   // Register byte addresses
   localparam logic [3:0] adrCtrl   = 4'h0;
   localparam logic [3:0] adrDiv    = 4'h4;
   localparam logic [3:0] adrStatus = 4'h8;
   localparam logic [3:0] adrData   = 4'hC;

   // Test modes from the data file
   localparam logic [1:0] modeLoop    = 2'd0;
   localparam logic [1:0] modeInject  = 2'd1;
   localparam logic [1:0] modeOverrun = 2'd2;

   // One line of the data file
   typedef struct packed {
      logic [1:0] mode;
      logic [7:0] ctrl;
      logic [7:0] ch;
      logic [1:0] fault;
      logic [7:0] expData;
      logic [7:0] expStat;
   } testRec;

   logic        clk;
   logic        rst;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [3:0]  wbAdr;
   logic [31:0] wbDatW;
   logic [31:0] wbDatR;
   logic        wbAck;
   wire         rxd;
   logic        txd;
   logic        irq;
   logic        loopEn;
   logic        serialLine;
   logic [7:0]  curCtrl;
   int          cycles = 0;
   int          cycleLimit = 0;
   testRec      tests[$];

   // Loopback or the serial driver
   assign rxd = loopEn ? txd : serialLine;

   uartTop #(
      .divWidth (16),
      .resetDiv (resetDiv)
   ) i_dut (
      .clk    (clk),
      .rst    (rst),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .wbDatR (wbDatR),
      .wbAck  (wbAck),
      .rxd    (rxd),
      .txd    (txd),
      .irq    (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Run limit armed once the tests are loaded
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if ((cycleLimit > 0) && (cycles >= cycleLimit))
      begin
         $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
         $display("TB FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic checkVal(input string name, input logic [31:0] got,
                           input logic [31:0] expVal);
      if (got !== expVal)
      begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expVal);
         $display("TB FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   //////////////////////////////
   // Wishbone master
   //////////////////////////////

   // Ack sampled on the falling edge and request dropped on the next rising edge
   task automatic waitAck(output logic [31:0] dat);
      @(negedge clk);
      while (!wbAck)
         @(negedge clk);
      dat = wbDatR;
      @(posedge clk);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe  <= 1'b0;
   endtask

   task automatic busWrite(input logic [3:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      @(posedge clk);
      wbCyc  <= 1'b1;
      wbStb  <= 1'b1;
      wbWe   <= 1'b1;
      wbAdr  <= adr;
      wbDatW <= dat;
      waitAck(unused);
   endtask

   task automatic busRead(input logic [3:0] adr, output logic [31:0] dat);
      @(posedge clk);
      wbCyc <= 1'b1;
      wbStb <= 1'b1;
      wbWe  <= 1'b0;
      wbAdr <= adr;
      waitAck(dat);
   endtask

   // Poll STATUS until every bit of mask is set
   task automatic waitStatus(input logic [7:0] mask);
      logic [31:0] stat;
      busRead(adrStatus, stat);
      while ((stat[7:0] & mask) != mask)
         busRead(adrStatus, stat);
   endtask

   //////////////////////////////
   // Serial driver
   //////////////////////////////

   task automatic driveBit(input logic b);
      @(posedge clk);
      serialLine <= b;
      repeat (bitClocks - 1) @(posedge clk);
   endtask

   // Fault 1 flips the parity bit and fault 2 sends a low first stop bit
   task automatic sendFrame(input logic [7:0] ctrl, input logic [7:0] ch,
                            input logic [1:0] fault);
      int         nBits;
      int         i;
      logic [7:0] sh;
      logic       par;
      nBits = 5 + int'(ctrl[4:3]);
      sh    = ch;
      par   = 1'b0;
      driveBit(1'b0);
      // LSB first with parity over the sent bits only
      for (i = 0; i < nBits; i++)
      begin
         driveBit(sh[0]);
         par = par ^ sh[0];
         sh  = sh >> 1;
      end
      // Odd parity inverts the even result
      if (ctrl[2:1] == 2'd2)
         par = ~par;
      if (fault == 2'd1)
         par = ~par;
      if ((ctrl[2:1] == 2'd1) || (ctrl[2:1] == 2'd2))
         driveBit(par);
      driveBit(fault != 2'd2);
      if (ctrl[0])
         driveBit(1'b1);
      driveBit(1'b1);
   endtask

   //////////////////////////////
   // Test table and runner
   //////////////////////////////

   task automatic loadTests;
      int         fd;
      int         nFields;
      int         faultIn;
      string      lineStr;
      string      modeTok;
      logic [7:0] ctrlIn;
      logic [7:0] charIn;
      logic [7:0] dataIn;
      logic [7:0] statIn;
      testRec     t;
      fd = $fopen("sim/uartTestdata.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open sim/uartTestdata.txt, run from the project root");
         $display("TB FAILED");
         $fatal(1, "missing test data");
      end
      while (!$feof(fd))
      begin
         lineStr = "";
         void'($fgets(lineStr, fd));
         // Skip comments and blank lines
         if ((lineStr.len() > 1) && (lineStr.getc(0) != "#"))
         begin
            nFields = $sscanf(lineStr, "%s %h %h %d %h %h", modeTok, ctrlIn, charIn,
                              faultIn, dataIn, statIn);
            if (nFields != 6)
            begin
               $display("Malformed line in the test data: %s", lineStr);
               $display("TB FAILED");
               $fatal(1, "bad test data");
            end
            if (modeTok == "loop")
               t.mode = modeLoop;
            else if (modeTok == "inject")
               t.mode = modeInject;
            else if (modeTok == "overrun")
               t.mode = modeOverrun;
            else
            begin
               $display("Unknown test mode in the test data: %s", modeTok);
               $display("TB FAILED");
               $fatal(1, "bad test data");
            end
            t.ctrl    = ctrlIn;
            t.ch      = charIn;
            t.fault   = 2'(faultIn);
            t.expData = dataIn;
            t.expStat = statIn;
            tests.push_back(t);
         end
      end
      $fclose(fd);
   endtask

   task automatic runTest(input testRec t);
      logic [31:0] rd;
      logic [7:0]  waitMask;
      logic        expIrq;
      // CTRL written only on a format change since the write clears the receiver
      if (t.ctrl != curCtrl)
      begin
         busWrite(adrCtrl, 32'(t.ctrl));
         curCtrl = t.ctrl;
      end
      @(posedge clk);
      loopEn   <= (t.mode == modeLoop);
      waitMask = 8'h18;
      case (t.mode)
         modeLoop:
         begin
            busWrite(adrData, 32'(t.ch));
            // Nothing pending while the frame goes out
            @(negedge clk);
            checkVal("irq while sending", 32'(irq), 32'd0);
         end
         modeInject:
            sendFrame(t.ctrl, t.ch, t.fault);
         default:
         begin
            // First character left unread
            sendFrame(t.ctrl, ~t.ch, 2'd0);
            waitStatus(8'h18);
            sendFrame(t.ctrl, t.ch, 2'd0);
            waitMask = 8'h19;
         end
      endcase
      waitStatus(waitMask);
      busRead(adrStatus, rd);
      checkVal("STATUS", rd, 32'(t.expStat));
      expIrq = (t.ctrl[5] && t.expStat[3]) || (t.ctrl[6] && t.expStat[4]);
      @(negedge clk);
      checkVal("irq", 32'(irq), 32'(expIrq));
      busRead(adrData, rd);
      checkVal("DATA", rd, 32'(t.expData));
      // Read clears full and leaves the error flags
      busRead(adrStatus, rd);
      checkVal("STATUS after DATA read", rd, 32'(t.expStat & 8'hF7));
      @(negedge clk);
      checkVal("irq after DATA read", 32'(irq), 32'(t.ctrl[6] && t.expStat[4]));
      if (t.mode == modeOverrun)
      begin
         busWrite(adrCtrl, 32'(t.ctrl));
         busRead(adrStatus, rd);
         checkVal("STATUS after CTRL write", rd, 32'h10);
         // Bad character left unread, then cleared by CTRL
         sendFrame(t.ctrl, t.ch, 2'd2);
         waitStatus(8'h1A);
         busWrite(adrCtrl, 32'(t.ctrl));
         busRead(adrStatus, rd);
         checkVal("STATUS after clearing full", rd, 32'h10);
      end
   endtask

   initial
   begin
      logic [31:0] rd;
      int          n;
      rst        = 1'b1;
      wbCyc      = 1'b0;
      wbStb      = 1'b0;
      wbWe       = 1'b0;
      wbAdr      = 4'h0;
      wbDatW     = 32'd0;
      loopEn     = 1'b0;
      serialLine = 1'b1;
      curCtrl    = 8'h00;
      loadTests();
      cycleLimit = tests.size() * 2000 + 1000;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Reset values
      busRead(adrCtrl, rd);
      checkVal("CTRL after reset", rd, 32'd0);
      busRead(adrDiv, rd);
      checkVal("DIV after reset", rd, 32'(resetDiv));
      busRead(adrStatus, rd);
      checkVal("STATUS after reset", rd, 32'h10);
      @(negedge clk);
      checkVal("irq after reset", 32'(irq), 32'd0);
      checkVal("txd after reset", 32'(txd), 32'd1);

      busWrite(adrDiv, 32'(testDiv));
      busRead(adrDiv, rd);
      checkVal("DIV", rd, 32'(testDiv));

      for (n = 0; n < tests.size(); n++)
         runTest(tests[n]);

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: uartTop.f
hdl/uartPkg.sv
hdl/uartBaudGen.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/uartRegs.sv
hdl/uartTop.sv
sim/uartTopTb.sv
